//--- design/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// convolution geometry and data widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_K      5                      // kernel side
`define CONV_TAPS   (`CONV_K * `CONV_K)    // window and kernel entries
`define PIX_W       6                      // pixel and coefficient width
`define SUM_W       18                     // result width, holds 25 x 63 x 63

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result buffer and bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FIFO_DEPTH  8                      // result entries
`define FIFO_CW     ($clog2(`FIFO_DEPTH + 1))  // count width, 0..depth
`define WB_AW       8                      // word address width
`define WB_DW       32                     // data width, full words only

`endif

//--- design/conv_types_pkg.sv
`include "conv_params.svh"

package conv_types_pkg;

  // one image sample and one kernel weight, both unsigned
  typedef logic [`PIX_W-1:0] pixel_t;
  typedef logic [`PIX_W-1:0] coef_t;

  typedef logic [2*`PIX_W-1:0] product_t;  // full 6x6 product
  typedef logic [`SUM_W-1:0] sum_t;

  // pushed column, row 0 in the low bits
  typedef logic [`CONV_K*`PIX_W-1:0] column_t;

endpackage

//--- design/wb_map_pkg.sv
`include "conv_params.svh"

package wb_map_pkg;

  typedef enum logic [2:0] {
    op_none,
    op_ctrl,
    op_status,
    op_column,
    op_result,
    op_kernel
  } reg_op_e;

  typedef enum logic {
    st_idle,
    st_ack
  } bus_state_e;

  // word addresses
  localparam logic [`WB_AW-1:0] adr_ctrl    = 'h00;
  localparam logic [`WB_AW-1:0] adr_status  = 'h01;
  localparam logic [`WB_AW-1:0] adr_column  = 'h02;
  localparam logic [`WB_AW-1:0] adr_result  = 'h03;
  localparam logic [`WB_AW-1:0] kernel_base = 'h20;  // 25 coefficients follow

  function automatic reg_op_e decode_op(input logic [`WB_AW-1:0] adr);
    if (adr == adr_ctrl) return op_ctrl;
    if (adr == adr_status) return op_status;
    if (adr == adr_column) return op_column;
    if (adr == adr_result) return op_result;
    if (adr >= kernel_base && adr < kernel_base + `CONV_TAPS) return op_kernel;
    return op_none;  // acks, reads zero
  endfunction

endpackage

//--- design/conv_wb_decode.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_wb_decode (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       wb_cyc,
  input  logic                                       wb_stb,
  input  logic                                       wb_we,
  input  logic [`WB_AW-1:0]                          wb_adr,
  input  logic [`WB_DW-1:0]                          wb_dat_w,
  output logic [`WB_DW-1:0]                          wb_dat_r,
  output logic                                       wb_ack,
  output logic                                       shift,
  output conv_types_pkg::column_t                    column,
  output logic                                       win_clear,
  output logic                                       compute,
  output conv_types_pkg::coef_t [`CONV_TAPS-1:0]     kernel,
  output logic                                       pop,
  output logic                                       ovf_clear,
  input  conv_types_pkg::sum_t                       head,
  input  logic [`FIFO_CW-1:0]                        count,
  input  logic                                       overflow,
  input  logic                                       win_full
);

  localparam int kiw = $clog2(`CONV_TAPS);

  wb_map_pkg::bus_state_e state, state_nxt;
  wb_map_pkg::reg_op_e    op;

  logic           enable;
  logic           wr_acc;
  logic           rd_acc;
  logic [kiw-1:0] kidx;

  assign op     = wb_map_pkg::decode_op(wb_adr);
  assign kidx   = kiw'(wb_adr - wb_map_pkg::kernel_base);  // coefficient index
  assign wb_ack = (state == wb_map_pkg::st_ack);
  assign wr_acc = wb_ack && wb_we;   // access completes in the ack cycle
  assign rd_acc = wb_ack && !wb_we;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus phase
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_nxt = state;
    case (state)
      wb_map_pkg::st_idle: if (wb_cyc && wb_stb) state_nxt = wb_map_pkg::st_ack;
      wb_map_pkg::st_ack:  state_nxt = wb_map_pkg::st_idle;  // one ack per request
      default:             state_nxt = wb_map_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= wb_map_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control and kernel registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable <= 1'b0;
      kernel <= '0;
    end else if (wr_acc) begin
      if (op == wb_map_pkg::op_ctrl) enable <= wb_dat_w[0];
      if (op == wb_map_pkg::op_kernel) kernel[kidx] <= wb_dat_w[`PIX_W-1:0];
    end
  end

  assign compute = enable;

  // datapath strobes, one cycle wide since ack is
  assign shift     = wr_acc && (op == wb_map_pkg::op_column);
  assign column    = wb_dat_w[`CONV_K*`PIX_W-1:0];  // master holds data through ack
  assign win_clear = wr_acc && (op == wb_map_pkg::op_ctrl) && wb_dat_w[1];
  assign ovf_clear = wr_acc && (op == wb_map_pkg::op_ctrl) && wb_dat_w[2];
  assign pop       = rd_acc && (op == wb_map_pkg::op_result);

  // read mux
  always_comb begin
    case (op)
      wb_map_pkg::op_ctrl:   wb_dat_r = `WB_DW'(enable);
      wb_map_pkg::op_status: wb_dat_r = `WB_DW'({enable, win_full, overflow, count});
      wb_map_pkg::op_result: wb_dat_r = `WB_DW'(head);   // zero when empty
      wb_map_pkg::op_kernel: wb_dat_r = `WB_DW'(kernel[kidx]);
      default:               wb_dat_r = '0;  // column writes and unmapped words
    endcase
  end

  a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack);

endmodule

//--- design/conv_window.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_window (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    shift,
  input  conv_types_pkg::column_t                 column,
  input  logic                                    win_clear,
  input  logic                                    compute,
  output logic                                    win_valid,
  output logic                                    win_full,
  output conv_types_pkg::pixel_t [`CONV_TAPS-1:0] window   // index row*K + col
);

  localparam int fw = $clog2(`CONV_K + 1);

  logic [fw-1:0] fill;  // loaded columns, saturates at K

  assign win_full = (fill == fw'(`CONV_K));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill      <= '0;
      win_valid <= 1'b0;
    end else begin
      // launch when this shift completes the window
      win_valid <= shift && compute && (fill >= fw'(`CONV_K - 1));
      if (win_clear) begin
        fill <= '0;
      end else if (shift && !win_full) begin
        fill <= fill + 1'b1;
      end
    end
  end

  // shift toward column 0, newest column enters at K-1
  always_ff @(posedge clk) begin
    if (shift) begin
      for (int r = 0; r < `CONV_K; r++) begin
        for (int c = 0; c < `CONV_K - 1; c++) begin
          window[r*`CONV_K + c] <= window[r*`CONV_K + c + 1];
        end
        window[r*`CONV_K + `CONV_K - 1] <= column[r*`PIX_W +: `PIX_W];
      end
    end
  end

  a_valid_after_shift: assert property (@(posedge clk) disable iff (!rst_n)
    win_valid |-> $past(shift));

endmodule

//--- design/conv_mac_tree.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_mac_tree (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    win_valid,
  input  conv_types_pkg::pixel_t [`CONV_TAPS-1:0] window,
  input  conv_types_pkg::coef_t  [`CONV_TAPS-1:0] kernel,
  output logic                                    sum_valid,
  output conv_types_pkg::sum_t                    sum
);

  conv_types_pkg::product_t [`CONV_TAPS-1:0] prod_q;
  logic                                      prod_valid;

  // adder tree levels for 25 terms
  conv_types_pkg::sum_t lvl1 [13];
  conv_types_pkg::sum_t lvl2 [7];
  conv_types_pkg::sum_t lvl3 [4];
  conv_types_pkg::sum_t lvl4 [2];
  conv_types_pkg::sum_t tree_sum;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 1: products
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    for (int i = 0; i < `CONV_TAPS; i++) begin
      prod_q[i] <= conv_types_pkg::product_t'(window[i]) *
                   conv_types_pkg::product_t'(kernel[i]);  // kernel sampled here
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 2: balanced reduction 25 -> 13 -> 7 -> 4 -> 2 -> 1
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < 12; i++) begin
      lvl1[i] = conv_types_pkg::sum_t'(prod_q[2*i]) +
                conv_types_pkg::sum_t'(prod_q[2*i+1]);
    end
    lvl1[12] = conv_types_pkg::sum_t'(prod_q[24]);  // odd term passes
    for (int i = 0; i < 6; i++) begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
    lvl2[6] = lvl1[12];
    for (int i = 0; i < 3; i++) begin
      lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
    end
    lvl3[3] = lvl2[6];
    lvl4[0] = lvl3[0] + lvl3[1];
    lvl4[1] = lvl3[2] + lvl3[3];
    tree_sum = lvl4[0] + lvl4[1];
  end

  always_ff @(posedge clk) begin
    sum <= tree_sum;
  end

  // valid pipe, one bit per stage so back-to-back windows overlap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      sum_valid  <= prod_valid;
    end
  end

endmodule

//--- design/conv_result_fifo.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_result_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sum_valid,
  input  conv_types_pkg::sum_t sum,
  input  logic                 pop,
  input  logic                 ovf_clear,
  output conv_types_pkg::sum_t head,
  output logic [`FIFO_CW-1:0]  count,
  output logic                 overflow
);

  localparam int aw = $clog2(`FIFO_DEPTH);

  conv_types_pkg::sum_t mem [`FIFO_DEPTH];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          empty;
  logic          full;
  logic          push;
  logic          do_pop;

  assign empty  = (count == '0);
  assign full   = (count == `FIFO_CW'(`FIFO_DEPTH));
  assign push   = sum_valid && !full;  // no stall path, full drops
  assign do_pop = pop && !empty;
  assign head   = empty ? '0 : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= sum;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // power-of-two depth wraps
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (sum_valid && full) begin
        overflow <= 1'b1;  // sticky, set wins over clear
      end else if (ovf_clear) begin
        overflow <= 1'b0;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= `FIFO_CW'(`FIFO_DEPTH));

endmodule

//--- design/conv_accel_top.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_accel_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`WB_AW-1:0] wb_adr,
  input  logic [`WB_DW-1:0] wb_dat_w,
  output logic [`WB_DW-1:0] wb_dat_r,
  output logic              wb_ack
);

  logic                                    shift;
  conv_types_pkg::column_t                 column;
  logic                                    win_clear;
  logic                                    compute;
  conv_types_pkg::coef_t [`CONV_TAPS-1:0]  kernel;
  logic                                    pop;
  logic                                    ovf_clear;
  conv_types_pkg::sum_t                    head;
  logic [`FIFO_CW-1:0]                     count;
  logic                                    overflow;
  logic                                    win_full;
  logic                                    win_valid;
  conv_types_pkg::pixel_t [`CONV_TAPS-1:0] window;
  logic                                    sum_valid;
  conv_types_pkg::sum_t                    sum;

  conv_wb_decode decode_i (
    .clk, .rst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .shift, .column, .win_clear, .compute, .kernel,
    .pop, .ovf_clear, .head, .count, .overflow, .win_full
  );

  // execute, shift to sum_valid is 3 cycles
  conv_window window_i (
    .clk, .rst_n,
    .shift, .column, .win_clear, .compute,
    .win_valid, .win_full, .window
  );

  conv_mac_tree mac_i (
    .clk, .rst_n,
    .win_valid, .window, .kernel,
    .sum_valid, .sum
  );

  conv_result_fifo fifo_i (
    .clk, .rst_n,
    .sum_valid, .sum, .pop, .ovf_clear,
    .head, .count, .overflow
  );

endmodule

//--- bench/conv_accel_tb.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_accel_tb;

  localparam int bus_accesses = 400;                          // all tests with polls
  localparam int watchdog_ns  = bus_accesses * 6 * 8 + 2000;
  localparam int pipe_cycles  = 4;                            // column ack to fifo entry

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [`WB_AW-1:0] wb_adr;
  logic [`WB_DW-1:0] wb_dat_w;
  logic [`WB_DW-1:0] wb_dat_r;
  logic              wb_ack;

  logic [31:0]            lfsr_state;
  conv_types_pkg::pixel_t ref_win [`CONV_K][`CONV_K];  // [row][col] with col 0 oldest
  conv_types_pkg::coef_t  ref_kern [`CONV_TAPS];
  int                     ref_fill;
  logic                   ref_en;
  logic                   ref_ovf;
  conv_types_pkg::sum_t   exp_q [$];                    // mirrors the result fifo

  conv_accel_top dut_i (
    .clk, .rst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    abort_run("watchdog expired before the tests finished");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reporting and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_sum(input conv_types_pkg::sum_t got, input conv_types_pkg::sum_t exp,
                           input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
      abort_run("result value check failed");
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      abort_run("register value check failed");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus access entered and left 1 ns after a rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_cycle(input logic we, input logic [`WB_AW-1:0] adr,
                           input logic [31:0] dat_w, output logic [31:0] dat_r);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat_w;
    waited   = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (!wb_ack && waited >= 4) abort_run("no bus acknowledge within 4 cycles");
    end while (!wb_ack);
    dat_r = wb_dat_r;  // valid in the ack cycle
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [`WB_AW-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [`WB_AW-1:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and model-aware helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic conv_types_pkg::sum_t window_sum();
    conv_types_pkg::sum_t acc;
    acc = '0;
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        acc += conv_types_pkg::sum_t'(ref_win[r][c]) *
               conv_types_pkg::sum_t'(ref_kern[r*`CONV_K + c]);
      end
    end
    return acc;
  endfunction

  function automatic logic [31:0] status_expect();
    return `WB_DW'({ref_en, ref_fill == `CONV_K, ref_ovf, `FIFO_CW'(exp_q.size())});
  endfunction

  task automatic push_column();
    conv_types_pkg::column_t col;
    logic launch;
    col    = conv_types_pkg::column_t'(rand_bits(`CONV_K * `PIX_W));
    launch = ref_en && (ref_fill >= `CONV_K - 1);  // this push completes the window
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K - 1; c++) begin
        ref_win[r][c] = ref_win[r][c+1];
      end
      ref_win[r][`CONV_K-1] = col[r*`PIX_W +: `PIX_W];
    end
    if (ref_fill < `CONV_K) ref_fill++;
    if (launch) begin
      if (exp_q.size() < `FIFO_DEPTH) begin
        exp_q.push_back(window_sum());
      end else begin
        ref_ovf = 1'b1;  // dropped on a full fifo
      end
    end
    wb_write(wb_map_pkg::adr_column, `WB_DW'(col));
  endtask

  task automatic write_ctrl(input logic en, input logic clr_win, input logic clr_ovf);
    ref_en = en;
    if (clr_win) ref_fill = 0;
    if (clr_ovf) ref_ovf = 1'b0;
    wb_write(wb_map_pkg::adr_ctrl, `WB_DW'({clr_ovf, clr_win, en}));
  endtask

  task automatic verify_status();
    logic [31:0] d;
    wb_read(wb_map_pkg::adr_status, d);
    check_word(d, status_expect(), "status");
  endtask

  task automatic wait_count(input int n);
    logic [31:0] d;
    int polls;
    polls = 0;
    do begin
      wb_read(wb_map_pkg::adr_status, d);
      polls++;
      if (d[`FIFO_CW-1:0] != `FIFO_CW'(n) && polls >= 20) begin
        abort_run("result count did not reach the expected value");
      end
    end while (d[`FIFO_CW-1:0] != `FIFO_CW'(n));
  endtask

  task automatic pop_result();
    logic [31:0] d;
    conv_types_pkg::sum_t exp;
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
    end else begin
      exp = '0;  // empty fifo reads zero
    end
    wb_read(wb_map_pkg::adr_result, d);
    check_sum(conv_types_pkg::sum_t'(d), exp, "result");
  endtask

  task automatic settle();
    repeat (pipe_cycles + 1) @(posedge clk);
    #1;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic reset_values();
    logic [31:0] d;
    verify_status();
    pop_result();
    for (int i = 0; i < `CONV_TAPS; i++) begin
      wb_read(wb_map_pkg::kernel_base + `WB_AW'(i), d);
      check_word(d, '0, "kernel after reset");
    end
    wb_read(`WB_AW'('h10), d);  // unmapped word
    check_word(d, '0, "unmapped read");
  endtask

  task automatic kernel_readback();
    logic [31:0] d;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      ref_kern[i] = conv_types_pkg::coef_t'(rand_bits(`PIX_W));
      wb_write(wb_map_pkg::kernel_base + `WB_AW'(i), `WB_DW'(ref_kern[i]));
    end
    for (int i = 0; i < `CONV_TAPS; i++) begin
      wb_read(wb_map_pkg::kernel_base + `WB_AW'(i), d);
      check_word(d, `WB_DW'(ref_kern[i]), "kernel readback");
    end
  endtask

  task automatic first_result();
    write_ctrl(1'b1, 1'b0, 1'b0);
    repeat (`CONV_K) push_column();
    wait_count(1);
    verify_status();
    pop_result();
    verify_status();
  endtask

  task automatic sliding_window();
    repeat (8) push_column();
    wait_count(8);
    repeat (8) pop_result();
    verify_status();
  endtask

  task automatic enable_and_clear();
    write_ctrl(1'b0, 1'b0, 1'b0);
    repeat (3) push_column();
    settle();
    verify_status();
    write_ctrl(1'b1, 1'b1, 1'b0);
    repeat (`CONV_K - 1) begin
      push_column();
      settle();
      verify_status();
    end
    push_column();
    wait_count(1);
    verify_status();
    pop_result();
  endtask

  task automatic overflow_and_clear();
    repeat (12) push_column();
    wait_count(`FIFO_DEPTH);
    settle();
    verify_status();  // count 8 with overflow
    repeat (`FIFO_DEPTH) pop_result();
    verify_status();
    write_ctrl(1'b1, 1'b0, 1'b1);
    verify_status();
  endtask

  initial begin
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    lfsr_state = 32'd93506;
    ref_fill   = 0;
    ref_en     = 1'b0;
    ref_ovf    = 1'b0;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      ref_kern[i] = '0;
      ref_win[i / `CONV_K][i % `CONV_K] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_values();
    kernel_readback();
    first_result();
    sliding_window();
    enable_and_clear();
    overflow_and_clear();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
design/conv_types_pkg.sv
design/wb_map_pkg.sv
design/conv_wb_decode.sv
design/conv_window.sv
design/conv_mac_tree.sv
design/conv_result_fifo.sv
design/conv_accel_top.sv
bench/conv_accel_tb.sv

//--- Makefile
# Verilator build for the convolution accelerator testbench
TOP       ?= conv_accel_tb
LOG       ?= sim.log
VERILATOR ?= verilator
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FLIST)) design/conv_params.svh
VFLAGS  := --timing --assert -f $(FLIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR)

# the log decides the verdict, the simulator exit code is not trusted
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
